//--- design/accel_defs.svh
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Bus and memory widths
`define IO_ADDR_W   8
`define IO_DATA_W   32
`define MEM_ADDR_W  8
`define LEN_W       8

// Rule table and queue depth
`define RULE_CNT    8
`define RULE_IDX_W  3
`define FIFO_AW     2

// Register byte offsets
`define REG_CTRL     8'h00
`define REG_LEN      8'h04
`define REG_ADDR     8'h08
`define REG_META     8'h0C
`define REG_RESULT   8'h10
`define REG_RULE     8'h14
`define REG_SRC_IP   8'h20
`define REG_IP_RES   8'h24
`define REG_DMA_STAT 8'h28

// Blocked /24 prefixes in host order
`define IP_BLOCK_0  24'hC0A801
`define IP_BLOCK_1  24'h0A0000
`define IP_BLOCK_2  24'hAC1020
`define IP_BLOCK_3  24'hC63364

`endif

//--- design/accel_pkg.sv
`include "accel_defs.svh"

package accel_pkg;

  typedef enum logic [1:0] {
    DMA_IDLE  = 2'd0,
    DMA_FETCH = 2'd1,
    DMA_DRAIN = 2'd2
  } dma_state_t;

  typedef enum logic [1:0] {
    M_WAIT_META = 2'd0,
    M_SCAN      = 2'd1,
    M_HOLD      = 2'd2
  } match_state_t;

  // Source IP as written by the core, bytes[0] is the first byte on the wire
  typedef union packed {
    logic [`IO_DATA_W-1:0]          word;
    logic [`IO_DATA_W/8-1:0][7:0]   bytes;
  } ip_word_u;

endpackage

//--- design/simple_fifo.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module simple_fifo #(
  parameter int DATA_W = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              din_valid,
  input  logic [DATA_W-1:0] din,
  output logic              din_ready,
  output logic              dout_valid,
  output logic [DATA_W-1:0] dout,
  input  logic              dout_ready
);
  localparam int DEPTH = 1 << `FIFO_AW;

  logic [DATA_W-1:0]   mem [DEPTH];
  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`FIFO_AW:0]   count;
  logic                push;
  logic                pop;

  assign din_ready  = (count != DEPTH[`FIFO_AW:0]);
  assign dout_valid = (count != '0);
  // Head entry shows without a read cycle
  assign dout = mem[rd_ptr];
  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + push - pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

//--- design/accel_regs.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module accel_regs
  import accel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    io_en,
  input  logic                    io_wen,
  input  logic [`IO_DATA_W/8-1:0] io_strb,
  input  logic [`IO_ADDR_W-1:0]   io_addr,
  input  logic [`IO_DATA_W-1:0]   io_wr_data,
  output logic [`IO_DATA_W-1:0]   io_rd_data,
  output logic                    io_rd_valid,
  output logic                    cmd_start,
  output logic                    cmd_release,
  output logic                    cmd_stop,
  output logic [`MEM_ADDR_W-1:0]  cmd_addr,
  output logic [`LEN_W-1:0]       cmd_len,
  output logic [7:0]              cmd_state,
  output logic [7:0]              cmd_slot,
  output ip_word_u                src_ip,
  output logic                    src_ip_valid,
  input  logic                    match_valid,
  input  logic                    result_valid,
  input  logic [`RULE_IDX_W-1:0]  match_rule,
  input  logic [7:0]              state_out,
  input  logic [7:0]              slot_out,
  input  logic                    dma_done,
  input  logic                    desc_ready,
  input  logic                    ip_hit,
  input  logic                    ip_done
);
  logic                  wr_en;
  logic                  rd_en;
  logic                  rd_stall;
  logic                  ip_ready;
  logic                  dma_done_flag;
  logic [`IO_DATA_W-1:0] rd_mux;

  assign wr_en = io_en && io_wen;
  assign rd_en = io_en && !io_wen;
  // A new source IP in flight makes the old done stale
  assign ip_ready = ip_done && !src_ip_valid;

  // Command pulses, one cycle each
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_start    <= 1'b0;
      cmd_release  <= 1'b0;
      cmd_stop     <= 1'b0;
      src_ip_valid <= 1'b0;
    end else begin
      cmd_start    <= wr_en && (io_addr == `REG_CTRL) && io_wr_data[0];
      cmd_release  <= wr_en && (io_addr == `REG_CTRL) && io_wr_data[1];
      cmd_stop     <= wr_en && (io_addr == `REG_CTRL) && io_wr_data[2];
      src_ip_valid <= wr_en && (io_addr == `REG_SRC_IP);
    end
  end

  // Sticky done, dma_done input pulses on the last word sent
  always_ff @(posedge clk) begin
    if (rst) begin
      dma_done_flag <= 1'b0;
    end else if (cmd_start) begin
      dma_done_flag <= 1'b0;
    end else if (dma_done || cmd_stop) begin
      dma_done_flag <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (io_addr)
        `REG_LEN:    cmd_len <= io_wr_data[`LEN_W-1:0];
        `REG_ADDR:   cmd_addr <= io_wr_data[`MEM_ADDR_W-1:0];
        `REG_META: begin
          if (io_strb[0]) begin
            cmd_state <= io_wr_data[7:0];
          end
          if (io_strb[1]) begin
            cmd_slot <= io_wr_data[15:8];
          end
        end
        `REG_SRC_IP: src_ip.word <= io_wr_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (io_addr)
      `REG_CTRL:     rd_mux[1:0] = {result_valid, match_valid};
      `REG_LEN:      rd_mux[`LEN_W-1:0] = cmd_len;
      `REG_ADDR:     rd_mux[`MEM_ADDR_W-1:0] = cmd_addr;
      `REG_META:     rd_mux[15:0] = {cmd_slot, cmd_state};
      `REG_RESULT:   rd_mux[15:0] = {slot_out, state_out};
      `REG_RULE:     rd_mux[`RULE_IDX_W-1:0] = match_rule;
      `REG_SRC_IP:   rd_mux = src_ip.word;
      `REG_DMA_STAT: begin
        rd_mux[0] = desc_ready;
        rd_mux[8] = dma_done_flag;
      end
      `REG_IP_RES:   rd_mux[0] = ip_hit;
      default: ;
    endcase
  end

  // IP result read waits for the checker, core holds io_addr meanwhile
  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
    end else begin
      io_rd_valid <= 1'b0;
      if (rd_en && (io_addr == `REG_IP_RES)) begin
        io_rd_valid <= ip_ready;
        rd_stall    <= !ip_ready;
      end else if (rd_en) begin
        io_rd_valid <= 1'b1;
      end else if (rd_stall) begin
        io_rd_valid <= ip_ready;
        rd_stall    <= !ip_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en || rd_stall) begin
      io_rd_data <= rd_mux;
    end
  end

endmodule

//--- design/pkt_rd_dma.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module pkt_rd_dma
  import accel_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`MEM_ADDR_W-1:0] desc_addr,
  input  logic [`LEN_W-1:0]      desc_len,
  input  logic                   desc_valid,
  output logic                   desc_ready,
  input  logic                   stop,
  output logic                   mem_rd_en,
  output logic [`MEM_ADDR_W-1:0] mem_rd_addr,
  input  logic [`IO_DATA_W-1:0]  mem_rd_data,
  output logic [`IO_DATA_W-1:0]  s_data,
  output logic                   s_last,
  output logic                   s_valid,
  input  logic                   s_ready,
  output logic                   last_sent
);
  dma_state_t             state;
  logic [`MEM_ADDR_W-1:0] rd_addr;
  logic [`LEN_W-1:0]      rd_left;
  logic [`LEN_W-1:0]      first_len;
  logic                   pend;
  logic                   pend_last;
  logic                   hold_valid;
  logic                   hold_last;
  logic [`IO_DATA_W-1:0]  hold_data;
  logic                   pop;
  logic                   xfer;
  logic                   hold_next;
  logic                   hold_load;
  logic                   flush;

  // Memory data goes straight out unless the holding slot is full
  assign s_valid   = hold_valid || pend;
  assign s_data    = hold_valid ? hold_data : mem_rd_data;
  assign s_last    = hold_valid ? hold_last : pend_last;
  assign xfer      = s_valid && s_ready;
  assign last_sent = xfer && s_last;
  assign pop       = desc_valid && desc_ready;
  assign first_len = (desc_len == '0) ? 1'b1 : desc_len;

  // Slot occupied after this edge, a new read only if it will be free
  assign hold_next = hold_valid ? (!xfer || pend) : (pend && !xfer);
  assign hold_load = pend && (hold_valid == xfer);
  assign flush     = stop && (state != DMA_IDLE) && !last_sent;

  assign mem_rd_en   = (state == DMA_FETCH) && !hold_next;
  assign mem_rd_addr = rd_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= DMA_IDLE;
      desc_ready <= 1'b0;
      rd_left    <= '0;
      pend       <= 1'b0;
      pend_last  <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      pend       <= mem_rd_en && !flush;
      pend_last  <= mem_rd_en && (rd_left == 1);
      hold_valid <= hold_next || flush;
      if (mem_rd_en) begin
        rd_left <= rd_left - 1'b1;
      end
      case (state)
        DMA_IDLE: begin
          desc_ready <= !pop;
          if (pop) begin
            state   <= DMA_FETCH;
            rd_left <= first_len;
          end
        end
        DMA_FETCH: begin
          if (mem_rd_en && (rd_left == 1)) begin
            state <= DMA_DRAIN;
          end
        end
        DMA_DRAIN: begin
          if (last_sent) begin
            state      <= DMA_IDLE;
            desc_ready <= 1'b1;
          end
        end
        default: state <= DMA_IDLE;
      endcase
      // Abort drops reads in flight and closes the stream
      if (flush) begin
        state <= DMA_DRAIN;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == DMA_IDLE) begin
      rd_addr <= desc_addr;
    end else if (mem_rd_en) begin
      rd_addr <= rd_addr + 1'b1;
    end
    if (flush) begin
      hold_data <= '0;
      hold_last <= 1'b1;
    end else if (hold_load) begin
      hold_data <= mem_rd_data;
      hold_last <= pend_last;
    end
  end

endmodule

//--- design/pair_matcher.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module pair_matcher
  import accel_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rule_wr_en,
  input  logic [`RULE_IDX_W-1:0] rule_wr_addr,
  input  logic [16:0]            rule_wr_data,
  input  logic [7:0]             meta_state,
  input  logic [7:0]             meta_slot,
  input  logic                   meta_valid,
  output logic                   meta_ready,
  input  logic [`IO_DATA_W-1:0]  s_data,
  input  logic                   s_last,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  logic                   match_release,
  output logic                   match_valid,
  output logic                   result_valid,
  output logic [`RULE_IDX_W-1:0] match_rule,
  output logic [7:0]             state_out,
  output logic [7:0]             slot_out
);
  match_state_t                state;
  logic [15:0]                 rule_pair [`RULE_CNT];
  logic [`RULE_CNT-1:0]        rule_en;
  logic [`IO_DATA_W/8:0][7:0]  chain;
  logic [7:0]                  prev_byte;
  logic [7:0]                  slot_q;
  logic                        found;
  logic [`RULE_IDX_W-1:0]      found_rule;
  logic                        word_hit;
  logic [`RULE_IDX_W-1:0]      word_rule;
  logic                        xfer;

  assign meta_ready   = (state == M_WAIT_META);
  assign s_ready      = (state == M_SCAN);
  assign result_valid = (state == M_HOLD);
  assign xfer         = s_valid && s_ready;
  // Byte before the word's first byte sits at the bottom
  assign chain        = {s_data, prev_byte};

  always_comb begin
    word_hit  = 1'b0;
    word_rule = '0;
    // Walk down so the earliest byte and then the lowest rule win
    for (int b = `IO_DATA_W/8 - 1; b >= 0; b--) begin
      for (int r = `RULE_CNT - 1; r >= 0; r--) begin
        if (rule_en[r] && (rule_pair[r] == {chain[b], chain[b+1]})) begin
          word_hit  = 1'b1;
          word_rule = r[`RULE_IDX_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rule_pair[rule_wr_addr] <= rule_wr_data[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rule_en     <= '0;
      state       <= M_WAIT_META;
      match_valid <= 1'b0;
      found       <= 1'b0;
    end else begin
      if (rule_wr_en) begin
        rule_en[rule_wr_addr] <= rule_wr_data[16];
      end
      case (state)
        M_WAIT_META: begin
          if (meta_valid) begin
            state <= M_SCAN;
            found <= 1'b0;
          end
        end
        M_SCAN: begin
          if (xfer && word_hit) begin
            found <= 1'b1;
          end
          if (xfer && s_last) begin
            state       <= M_HOLD;
            match_valid <= found || word_hit;
          end
        end
        M_HOLD: begin
          if (match_release) begin
            state       <= M_WAIT_META;
            match_valid <= 1'b0;
          end
        end
        default: state <= M_WAIT_META;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (meta_valid && meta_ready) begin
      prev_byte <= meta_state;
      slot_q    <= meta_slot;
    end else if (xfer) begin
      prev_byte <= s_data[`IO_DATA_W-1 -: 8];
    end
    if (xfer && word_hit && !found) begin
      found_rule <= word_rule;
    end
    if (xfer && s_last) begin
      match_rule <= found ? found_rule : word_rule;
      state_out  <= s_data[`IO_DATA_W-1 -: 8];
      slot_out   <= slot_q;
    end
  end

endmodule

//--- design/ip_match.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module ip_match
  import accel_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  ip_word_u addr,
  input  logic     valid,
  output logic     match,
  output logic     done
);
  logic [`IO_DATA_W-1:0] host_ip;
  logic                  cmp_pending;
  logic                  prefix_hit;

  // Top 24 bits of the host-order address against each prefix
  assign prefix_hit = (host_ip[31:8] == `IP_BLOCK_0) ||
                      (host_ip[31:8] == `IP_BLOCK_1) ||
                      (host_ip[31:8] == `IP_BLOCK_2) ||
                      (host_ip[31:8] == `IP_BLOCK_3);

  // Network order to host order
  always_ff @(posedge clk) begin
    if (valid) begin
      host_ip <= {addr.bytes[0], addr.bytes[1], addr.bytes[2], addr.bytes[3]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_pending <= 1'b0;
      match       <= 1'b0;
      done        <= 1'b0;
    end else begin
      cmp_pending <= valid;
      if (valid) begin
        match <= 1'b0;
        done  <= 1'b0;
      end else if (cmp_pending) begin
        match <= prefix_hit;
        done  <= 1'b1;
      end
    end
  end

endmodule

//--- design/accel_top.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module accel_top
  import accel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    io_en,
  input  logic                    io_wen,
  input  logic [`IO_DATA_W/8-1:0] io_strb,
  input  logic [`IO_ADDR_W-1:0]   io_addr,
  input  logic [`IO_DATA_W-1:0]   io_wr_data,
  output logic [`IO_DATA_W-1:0]   io_rd_data,
  output logic                    io_rd_valid,
  input  logic                    rule_wr_en,
  input  logic [`RULE_IDX_W-1:0]  rule_wr_addr,
  input  logic [16:0]             rule_wr_data,
  output logic                    mem_rd_en,
  output logic [`MEM_ADDR_W-1:0]  mem_rd_addr,
  input  logic [`IO_DATA_W-1:0]   mem_rd_data
);
  logic                   cmd_start;
  logic                   cmd_release;
  logic                   cmd_stop;
  logic [`MEM_ADDR_W-1:0] cmd_addr;
  logic [`LEN_W-1:0]      cmd_len;
  logic [7:0]             cmd_state;
  logic [7:0]             cmd_slot;
  ip_word_u               src_ip;
  logic                   src_ip_valid;
  logic                   match_valid;
  logic                   result_valid;
  logic [`RULE_IDX_W-1:0] match_rule;
  logic [7:0]             state_out;
  logic [7:0]             slot_out;
  logic                   last_sent;
  logic                   ip_hit;
  logic                   ip_done;
  logic [`MEM_ADDR_W-1:0] desc_addr;
  logic [`LEN_W-1:0]      desc_len;
  logic                   desc_valid;
  logic                   desc_ready;
  logic [7:0]             meta_state;
  logic [7:0]             meta_slot;
  logic                   meta_valid;
  logic                   meta_ready;
  logic [`IO_DATA_W-1:0]  s_data;
  logic                   s_last;
  logic                   s_valid;
  logic                   s_ready;

  accel_regs regs (
    .clk(clk),
    .rst(rst),
    .io_en(io_en),
    .io_wen(io_wen),
    .io_strb(io_strb),
    .io_addr(io_addr),
    .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid),
    .cmd_start(cmd_start),
    .cmd_release(cmd_release),
    .cmd_stop(cmd_stop),
    .cmd_addr(cmd_addr),
    .cmd_len(cmd_len),
    .cmd_state(cmd_state),
    .cmd_slot(cmd_slot),
    .src_ip(src_ip),
    .src_ip_valid(src_ip_valid),
    .match_valid(match_valid),
    .result_valid(result_valid),
    .match_rule(match_rule),
    .state_out(state_out),
    .slot_out(slot_out),
    .dma_done(last_sent),
    .desc_ready(desc_ready),
    .ip_hit(ip_hit),
    .ip_done(ip_done)
  );

  // Descriptor and metadata are pushed together, popped on their own
  simple_fifo #(.DATA_W(`MEM_ADDR_W + `LEN_W)) desc_fifo (
    .clk(clk),
    .rst(rst),
    .din_valid(cmd_start),
    .din({cmd_addr, cmd_len}),
    .din_ready(),
    .dout_valid(desc_valid),
    .dout({desc_addr, desc_len}),
    .dout_ready(desc_ready)
  );

  simple_fifo #(.DATA_W(16)) meta_fifo (
    .clk(clk),
    .rst(rst),
    .din_valid(cmd_start),
    .din({cmd_state, cmd_slot}),
    .din_ready(),
    .dout_valid(meta_valid),
    .dout({meta_state, meta_slot}),
    .dout_ready(meta_ready)
  );

  pkt_rd_dma dma (
    .clk(clk),
    .rst(rst),
    .desc_addr(desc_addr),
    .desc_len(desc_len),
    .desc_valid(desc_valid),
    .desc_ready(desc_ready),
    .stop(cmd_stop),
    .mem_rd_en(mem_rd_en),
    .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data),
    .s_data(s_data),
    .s_last(s_last),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .last_sent(last_sent)
  );

  pair_matcher matcher (
    .clk(clk),
    .rst(rst),
    .rule_wr_en(rule_wr_en),
    .rule_wr_addr(rule_wr_addr),
    .rule_wr_data(rule_wr_data),
    .meta_state(meta_state),
    .meta_slot(meta_slot),
    .meta_valid(meta_valid),
    .meta_ready(meta_ready),
    .s_data(s_data),
    .s_last(s_last),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .match_release(cmd_release),
    .match_valid(match_valid),
    .result_valid(result_valid),
    .match_rule(match_rule),
    .state_out(state_out),
    .slot_out(slot_out)
  );

  ip_match ip_check (
    .clk(clk),
    .rst(rst),
    .addr(src_ip),
    .valid(src_ip_valid),
    .match(ip_hit),
    .done(ip_done)
  );

endmodule

//--- verification/accel_tb.sv
`timescale 1ns/1ns
`include "accel_defs.svh"

module accel_tb;
  localparam int MAX_ROWS     = 128;
  localparam int OP_WRITE     = 0;
  localparam int OP_READ      = 1;
  localparam int OP_WAIT      = 2;
  localparam int OP_IDLE      = 3;
  localparam int READ_POLLS   = 16;
  localparam int RESULT_POLLS = 200;

  logic                    clk;
  logic                    rst;
  logic                    io_en;
  logic                    io_wen;
  logic [`IO_DATA_W/8-1:0] io_strb;
  logic [`IO_ADDR_W-1:0]   io_addr;
  logic [`IO_DATA_W-1:0]   io_wr_data;
  logic [`IO_DATA_W-1:0]   io_rd_data;
  logic                    io_rd_valid;
  logic                    rule_wr_en;
  logic [`RULE_IDX_W-1:0]  rule_wr_addr;
  logic [16:0]             rule_wr_data;
  logic                    mem_rd_en;
  logic [`MEM_ADDR_W-1:0]  mem_rd_addr;
  logic [`IO_DATA_W-1:0]   mem_rd_data;

  logic [31:0]          mem [256];
  logic                 mem_req;
  logic [7:0]           mem_req_addr;
  logic [15:0]          rule_tab [`RULE_CNT];
  logic [`RULE_CNT-1:0] rule_on;

  // Stimulus table, one entry per register operation
  int          row_op   [MAX_ROWS];
  logic [7:0]  row_addr [MAX_ROWS];
  logic [31:0] row_data [MAX_ROWS];
  logic [3:0]  row_strb [MAX_ROWS];
  logic [31:0] row_mask [MAX_ROWS];
  logic [31:0] row_exp  [MAX_ROWS];
  string       row_name [MAX_ROWS];

  int n_rows;
  int cycles;
  int cycle_limit;
  int checks;
  int value_errors;
  int timeouts;

  accel_top UUT (
    .clk(clk),
    .rst(rst),
    .io_en(io_en),
    .io_wen(io_wen),
    .io_strb(io_strb),
    .io_addr(io_addr),
    .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid),
    .rule_wr_en(rule_wr_en),
    .rule_wr_addr(rule_wr_addr),
    .rule_wr_data(rule_wr_data),
    .mem_rd_en(mem_rd_en),
    .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data)
  );

  always #20 clk = ~clk;

  // Packet memory, the request is taken on the rising edge and answered on the falling one
  always @(posedge clk) begin
    mem_req      <= mem_rd_en;
    mem_req_addr <= mem_rd_addr;
  end

  always @(negedge clk) begin
    if (mem_req) begin
      mem_rd_data <= mem[mem_req_addr];
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("cycle limit of %0d reached before the table finished", cycle_limit);
      $display("checks run: %0d, value errors: %0d, timeouts: %0d",
               checks, value_errors, timeouts + 1);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // First enabled rule at the earliest byte, returns {hit, rule, last byte}
  function automatic logic [11:0] predict_match(input logic [7:0] base, input int words,
                                                input logic [7:0] state);
    logic [7:0] prev;
    logic [7:0] cur;
    logic [7:0] idx;
    logic       hit;
    logic [2:0] rule;
    prev = state;
    hit  = 1'b0;
    rule = '0;
    for (int i = 0; i < words; i++) begin
      idx = base + i[7:0];
      for (int b = 0; b < 4; b++) begin
        cur = mem[idx][8*b +: 8];
        for (int r = 0; r < `RULE_CNT; r++) begin
          if (!hit && rule_on[r] && (rule_tab[r] == {prev, cur})) begin
            hit  = 1'b1;
            rule = r[2:0];
          end
        end
        prev = cur;
      end
    end
    return {hit, rule, prev};
  endfunction

  task automatic set_rules();
    rule_tab[0] = 16'hA55A;
    rule_tab[1] = 16'h3CC3;
    rule_tab[2] = 16'h7788;
    rule_tab[3] = 16'hDEAD;
    rule_tab[4] = 16'h1234;
    rule_tab[5] = 16'hF00F;
    rule_tab[6] = 16'h3CC3;
    rule_tab[7] = 16'h9966;
    // Rule 3 stays disabled
    rule_on = 8'b1111_0111;
  endtask

  task automatic fill_memory();
    logic [31:0] rng;
    rng = 32'd6681;
    for (int a = 0; a < 256; a++) begin
      rng    = xorshift32(rng);
      mem[a] = rng;
    end
    // Packet at 0x10: disabled pair, then rule 1 and 6 pair, then rule 7 pair
    mem[8'h11][15:0] = 16'hADDE;
    mem[8'h12][23:8] = 16'hC33C;
    mem[8'h13][15:0] = 16'h6699;
    // Packet at 0x20: first byte completes rule 0 only after 0xA5
    mem[8'h20] = 32'h0403025A;
    mem[8'h21] = 32'h08070605;
    mem[8'h30][15:0] = 16'h3412;
    mem[8'h40][7:0]  = 8'h88;
  endtask

  task automatic load_rules();
    for (int r = 0; r < `RULE_CNT; r++) begin
      rule_wr_en   = 1'b1;
      rule_wr_addr = r[2:0];
      rule_wr_data = {rule_on[r], rule_tab[r]};
      @(negedge clk);
    end
    rule_wr_en = 1'b0;
  endtask

  task automatic add_row(input int op, input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [31:0] mask,
                         input logic [31:0] expv, input string name);
    row_op[n_rows]   = op;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_strb[n_rows] = strb;
    row_mask[n_rows] = mask;
    row_exp[n_rows]  = expv;
    row_name[n_rows] = name;
    n_rows++;
  endtask

  task automatic write_row(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input string name);
    add_row(OP_WRITE, addr, data, strb, '0, '0, name);
  endtask

  task automatic read_row(input logic [7:0] addr, input logic [31:0] mask,
                          input logic [31:0] expv, input string name);
    add_row(OP_READ, addr, '0, '0, mask, expv, name);
  endtask

  task automatic queue_packet(input logic [7:0] base, input int words,
                              input logic [7:0] state, input logic [7:0] slot);
    write_row(`REG_LEN, words, 4'hF, "REG_LEN");
    write_row(`REG_ADDR, {24'h0, base}, 4'hF, "REG_ADDR");
    write_row(`REG_META, {16'h0, slot, state}, 4'hF, "REG_META");
    write_row(`REG_CTRL, 32'h1, 4'hF, "REG_CTRL");
  endtask

  task automatic expect_result(input logic [7:0] base, input int words, input logic [7:0] state,
                               input logic [7:0] slot, input bit check_done);
    logic [11:0] pred;
    pred = predict_match(base, words, state);
    add_row(OP_WAIT, `REG_CTRL, '0, '0, '0, '0, "result_valid");
    read_row(`REG_CTRL, '1, {30'h0, 1'b1, pred[11]}, "REG_CTRL");
    read_row(`REG_RESULT, '1, {16'h0, slot, pred[7:0]}, "REG_RESULT");
    if (pred[11]) begin
      read_row(`REG_RULE, '1, {29'h0, pred[10:8]}, "REG_RULE");
    end
    if (check_done) begin
      read_row(`REG_DMA_STAT, 32'h100, 32'h100, "REG_DMA_STAT");
    end
  endtask

  task automatic build_table();
    logic [11:0] pred_d;
    // Reset values and readback merged by byte lane
    read_row(`REG_CTRL, '1, 32'h0, "REG_CTRL");
    read_row(`REG_DMA_STAT, 32'h100, 32'h0, "REG_DMA_STAT");
    write_row(`REG_LEN, 32'h6, 4'hF, "REG_LEN");
    write_row(`REG_ADDR, 32'h5C, 4'hF, "REG_ADDR");
    write_row(`REG_META, 32'h5634, 4'hF, "REG_META");
    write_row(`REG_META, 32'hEEEE_99FF, 4'b0010, "REG_META");
    write_row(`REG_SRC_IP, 32'hDEADBEEF, 4'hF, "REG_SRC_IP");
    read_row(`REG_LEN, '1, 32'h6, "REG_LEN");
    read_row(`REG_ADDR, '1, 32'h5C, "REG_ADDR");
    read_row(`REG_META, '1, 32'h9934, "REG_META");
    read_row(`REG_SRC_IP, '1, 32'hDEADBEEF, "REG_SRC_IP");

    queue_packet(8'h10, 4, 8'h00, 8'h21);
    expect_result(8'h10, 4, 8'h00, 8'h21, 1'b1);
    write_row(`REG_CTRL, 32'h2, 4'hF, "REG_CTRL");
    // Carried state completes the pair, then the same words without it
    queue_packet(8'h20, 2, 8'hA5, 8'h31);
    expect_result(8'h20, 2, 8'hA5, 8'h31, 1'b1);
    write_row(`REG_CTRL, 32'h2, 4'hF, "REG_CTRL");
    queue_packet(8'h20, 2, 8'h01, 8'h32);
    expect_result(8'h20, 2, 8'h01, 8'h32, 1'b1);
    write_row(`REG_CTRL, 32'h2, 4'hF, "REG_CTRL");

    // Two descriptors queued, the second waits for release
    pred_d = predict_match(8'h30, 3, 8'h00);
    queue_packet(8'h30, 3, 8'h00, 8'h44);
    queue_packet(8'h40, 5, 8'h77, 8'h55);
    expect_result(8'h30, 3, 8'h00, 8'h44, 1'b0);
    add_row(OP_IDLE, '0, 32'd20, '0, '0, '0, "idle");
    read_row(`REG_RESULT, '1, {16'h0, 8'h44, pred_d[7:0]}, "REG_RESULT");
    read_row(`REG_CTRL, '1, {30'h0, 1'b1, pred_d[11]}, "REG_CTRL");
    write_row(`REG_CTRL, 32'h2, 4'hF, "REG_CTRL");
    expect_result(8'h40, 5, 8'h77, 8'h55, 1'b1);
    write_row(`REG_CTRL, 32'h2, 4'hF, "REG_CTRL");

    // Abort a long packet, the stream closes with a zero word
    queue_packet(8'h80, 60, 8'h00, 8'h66);
    read_row(`REG_CTRL, '1, 32'h0, "REG_CTRL");
    read_row(`REG_DMA_STAT, 32'h100, 32'h0, "REG_DMA_STAT");
    write_row(`REG_CTRL, 32'h4, 4'hF, "REG_CTRL");
    add_row(OP_WAIT, `REG_CTRL, '0, '0, '0, '0, "result_valid");
    read_row(`REG_CTRL, 32'h2, 32'h2, "REG_CTRL");
    read_row(`REG_DMA_STAT, 32'h100, 32'h100, "REG_DMA_STAT");
    read_row(`REG_RESULT, '1, {16'h0, 8'h66, 8'h00}, "REG_RESULT");
    write_row(`REG_CTRL, 32'h2, 4'hF, "REG_CTRL");

    // Source IPs in network order, first byte on the wire in bits 7:0
    write_row(`REG_SRC_IP, 32'h0501A8C0, 4'hF, "REG_SRC_IP");
    read_row(`REG_IP_RES, '1, 32'h1, "REG_IP_RES");
    write_row(`REG_SRC_IP, 32'h3300000A, 4'hF, "REG_SRC_IP");
    read_row(`REG_IP_RES, '1, 32'h1, "REG_IP_RES");
    write_row(`REG_SRC_IP, 32'h0501A8C1, 4'hF, "REG_SRC_IP");
    read_row(`REG_IP_RES, '1, 32'h0, "REG_IP_RES");
    write_row(`REG_SRC_IP, 32'hC0A80105, 4'hF, "REG_SRC_IP");
    read_row(`REG_IP_RES, '1, 32'h0, "REG_IP_RES");
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    io_strb    = strb;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // io_addr stays put until the response, the IP result may stall
  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data, output logic ok);
    int n;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    n = 0;
    while ((io_rd_valid !== 1'b1) && (n < READ_POLLS)) begin
      @(negedge clk);
      n++;
    end
    ok   = (io_rd_valid === 1'b1);
    data = io_rd_data;
  endtask

  task automatic run_row(input int i);
    logic [31:0] d;
    logic        ok;
    logic        seen;
    int          n;
    case (row_op[i])
      OP_WRITE: reg_write(row_addr[i], row_data[i], row_strb[i]);
      OP_READ: begin
        reg_read(row_addr[i], d, ok);
        checks++;
        if (!ok) begin
          $display("read of %s at row %0d got no io_rd_valid by %0t", row_name[i], i, $time);
          timeouts++;
        end else if ((d & row_mask[i]) !== (row_exp[i] & row_mask[i])) begin
          $display("FAIL time=%0t %s expected=%h actual=%h", $time, row_name[i],
                   row_exp[i] & row_mask[i], d & row_mask[i]);
          value_errors++;
        end
      end
      OP_WAIT: begin
        // Let a release or a start reach the matcher before polling
        repeat (2) @(negedge clk);
        seen = 1'b0;
        n    = 0;
        while (!seen && (n < RESULT_POLLS)) begin
          reg_read(`REG_CTRL, d, ok);
          seen = ok && d[1];
          n++;
        end
        if (!seen) begin
          $display("result_valid never rose while waiting at row %0d", i);
          timeouts++;
        end
      end
      default: repeat (row_data[i]) @(negedge clk);
    endcase
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr_en   = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    mem_rd_data  = '0;
    n_rows       = 0;
    cycles       = 0;
    checks       = 0;
    value_errors = 0;
    timeouts     = 0;
    set_rules();
    fill_memory();
    build_table();
    cycle_limit = n_rows * 64;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    load_rules();
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("checks run: %0d, value errors: %0d, timeouts: %0d",
             checks, value_errors, timeouts);
    if ((value_errors == 0) && (timeouts == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+design
design/accel_pkg.sv
design/simple_fifo.sv
design/accel_regs.sv
design/pkt_rd_dma.sv
design/pair_matcher.sv
design/ip_match.sv
design/accel_top.sv
verification/accel_tb.sv

//--- Bender.yml
package:
  name: accel_wrapper

export_include_dirs:
  - design

sources:
  - design/accel_pkg.sv
  - design/simple_fifo.sv
  - design/accel_regs.sv
  - design/pkt_rd_dma.sv
  - design/pair_matcher.sv
  - design/ip_match.sv
  - design/accel_top.sv
  - target: simulation
    files:
      - verification/accel_tb.sv
